//--- dv/controlChecker.sv
`timescale 1ns/1ns

module controlChecker import mipsCtrlPkg::*; (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic [instrWidth-1:0] instr,
    input  logic                  idStall,
    input  logic                  cmpEq,
    input  logic                  cmpGz,
    input  logic                  cmpGez,
    input  logic                  cmpLz,
    input  logic                  cmpLez,
    input  pcSrc_e                pcSrc,
    input  logic                  nextIsDelay,
    input  logic                  signExtend,
    input  logic                  link,
    input  logic                  regDst,
    input  logic                  aluSrcImm,
    input  aluOp_e                aluOp,
    input  logic                  memRead,
    input  logic                  memWrite,
    input  logic                  memByte,
    input  logic                  memHalf,
    input  logic                  memSignExtend,
    input  logic                  regWrite,
    input  logic                  memToReg,
    output int                    errorCount,
    output int                    checkCount
);

    int     errors = 0;
    int     checks = 0;
    logic   primed = 1'b0;
    pcSrc_e expPcSrc;
    aluOp_e expAluOp;
    logic   expDelay, expSignExt, expLink, expRegDst, expAluSrcImm;
    logic   expMemRead, expMemWrite, expMemByte, expMemHalf, expMemSignExt;
    logic   expRegWrite, expMemToReg;

    assign errorCount = errors;
    assign checkCount = checks;

    task automatic setBubble();
        expPcSrc      = pcSeq;
        expAluOp      = aluAddu;
        expDelay      = 1'b0;
        expSignExt    = 1'b0;
        expLink       = 1'b0;
        expRegDst     = 1'b0;
        expAluSrcImm  = 1'b0;
        expMemRead    = 1'b0;
        expMemWrite   = 1'b0;
        expMemByte    = 1'b0;
        expMemHalf    = 1'b0;
        expMemSignExt = 1'b0;
        expRegWrite   = 1'b0;
        expMemToReg   = 1'b0;
    endtask

    // Expected ID/EX contents for one decoded word
    task automatic predict(input logic [31:0] word, input logic bubble);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rtf;
        logic       taken;
        logic       known;
        op    = word[31:26];
        fn    = word[5:0];
        rtf   = word[20:16];
        taken = 1'b0;
        known = 1'b1;
        setBubble();
        if (!bubble) begin
            case (op)
                opTypeR: begin
                    case (fn)
                        fnAdd:  expAluOp = aluAdd;
                        fnAddu: expAluOp = aluAddu;
                        fnSub:  expAluOp = aluSub;
                        fnSubu: expAluOp = aluSubu;
                        fnAnd:  expAluOp = aluAnd;
                        fnOr:   expAluOp = aluOr;
                        fnXor:  expAluOp = aluXor;
                        fnNor:  expAluOp = aluNor;
                        fnSlt:  expAluOp = aluSlt;
                        fnSltu: expAluOp = aluSltu;
                        fnSll:  expAluOp = aluSll;
                        fnSrl:  expAluOp = aluSrl;
                        fnSra:  expAluOp = aluSra;
                        fnSllv: expAluOp = aluSllv;
                        fnSrlv: expAluOp = aluSrlv;
                        fnSrav: expAluOp = aluSrav;
                        fnJr, fnJalr: begin
                            expPcSrc = pcJumpReg;
                            expDelay = 1'b1;
                        end
                        default: known = 1'b0;
                    endcase
                    expRegDst   = known && (fn != fnJr);
                    expRegWrite = expRegDst;
                    expLink     = (fn == fnJalr);
                end
                opTypeBI: begin
                    if (rtf inside {rtBltz, rtBgez, rtBltzal, rtBgezal}) begin
                        // Bit 0 of rt selects >= 0, bit 4 adds the link
                        taken       = rtf[0] ? cmpGez : cmpLz;
                        expLink     = rtf[4];
                        expRegWrite = rtf[4];
                        expPcSrc    = taken ? pcBranch : pcSeq;
                        expDelay    = 1'b1;
                    end else begin
                        known = 1'b0;
                    end
                end
                opBeq, opBne, opBlez, opBgtz: begin
                    case (op)
                        opBeq:   taken = cmpEq;
                        opBne:   taken = !cmpEq;
                        opBlez:  taken = cmpLez;
                        default: taken = cmpGz;
                    endcase
                    expPcSrc = taken ? pcBranch : pcSeq;
                    expDelay = 1'b1;
                end
                opJ, opJal: begin
                    expPcSrc    = pcJumpImm;
                    expDelay    = 1'b1;
                    expLink     = (op == opJal);
                    expRegWrite = (op == opJal);
                end
                opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                    expAluSrcImm = 1'b1;
                    expRegWrite  = 1'b1;
                    case (op)
                        opAddi:  expAluOp = aluAdd;
                        opAddiu: expAluOp = aluAddu;
                        opSlti:  expAluOp = aluSlt;
                        opSltiu: expAluOp = aluSltu;
                        opAndi:  expAluOp = aluAnd;
                        opOri:   expAluOp = aluOr;
                        opXori:  expAluOp = aluXor;
                        default: expAluOp = aluSllc;
                    endcase
                end
                opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw: begin
                    expAluSrcImm  = 1'b1;
                    expMemRead    = !op[3];
                    expMemWrite   = op[3];
                    expRegWrite   = !op[3];
                    expMemToReg   = !op[3];
                    expMemByte    = op inside {opLb, opLbu, opSb};
                    expMemHalf    = op inside {opLh, opLhu, opSh};
                    expMemSignExt = op inside {opLb, opLh};
                end
                default: known = 1'b0;
            endcase
            expSignExt = known && !(op inside {opAndi, opOri, opXori, opLui});
            if (!known) begin
                setBubble();
            end
        end
    endtask

    task automatic compareField(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // Inputs are stable at the rising edge
    always @(posedge clock) begin
        predict(instr, !rstN || idStall);
        primed = 1'b1;
    end

    // Registered outputs settle well before the falling edge
    always @(negedge clock) begin
        if (primed) begin
            compareField("pcSrc", int'(expPcSrc), int'(pcSrc));
            compareField("nextIsDelay", int'(expDelay), int'(nextIsDelay));
            compareField("signExtend", int'(expSignExt), int'(signExtend));
            compareField("link", int'(expLink), int'(link));
            compareField("regDst", int'(expRegDst), int'(regDst));
            compareField("aluSrcImm", int'(expAluSrcImm), int'(aluSrcImm));
            compareField("aluOp", int'(expAluOp), int'(aluOp));
            compareField("memRead", int'(expMemRead), int'(memRead));
            compareField("memWrite", int'(expMemWrite), int'(memWrite));
            compareField("memByte", int'(expMemByte), int'(memByte));
            compareField("memHalf", int'(expMemHalf), int'(memHalf));
            compareField("memSignExtend", int'(expMemSignExt), int'(memSignExtend));
            compareField("regWrite", int'(expRegWrite), int'(regWrite));
            compareField("memToReg", int'(expMemToReg), int'(memToReg));
        end
    end

endmodule

//--- dv/mipsControlTb.sv
`timescale 1ns/1ns

module mipsControlTb import mipsCtrlPkg::*; ();

    localparam int resetCycles  = 5;
    localparam int totalVectors = 600 + 400 + 600 + 300 + 300;
    localparam int timeoutNs    = (resetCycles + totalVectors + 20) * 20;

    localparam int kindAluImm  = 0;
    localparam int kindMemory  = 1;
    localparam int kindFlow    = 2;
    localparam int kindStall   = 3;
    localparam int kindUnknown = 4;

    localparam logic [5:0] aluFuncts [16] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
        fnXor, fnNor, fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};
    localparam logic [5:0] memOps [8] = '{opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
    localparam logic [4:0] regimmCodes [4] = '{rtBltz, rtBgez, rtBltzal, rtBgezal};

    logic                  clock = 1'b0;
    logic                  rstN;
    logic [instrWidth-1:0] instr;
    logic                  idStall;
    logic                  cmpEq, cmpGz, cmpGez, cmpLz, cmpLez;
    pcSrc_e                pcSrc;
    aluOp_e                aluOp;
    logic                  nextIsDelay, signExtend, link, regDst, aluSrcImm;
    logic                  memRead, memWrite, memByte, memHalf, memSignExtend;
    logic                  regWrite, memToReg;
    int                    errorCount;
    int                    checkCount;
    int                    errorsAtStart = 0;
    int                    passedTests = 0;
    int                    failedTests = 0;

    always #10 clock = ~clock;

    mipsControl u_mipsControl (.*);

    controlChecker u_controlChecker (.*);

    function automatic logic [31:0] makeAluInstr();
        logic [31:0] word;
        word = $urandom;
        if (1'($urandom)) begin
            word[31:26] = opTypeR;
            word[5:0]   = aluFuncts[4'($urandom)];
        end else begin
            word[31:26] = {3'b001, 3'($urandom)};
        end
        return word;
    endfunction

    function automatic logic [31:0] makeMemInstr();
        logic [31:0] word;
        word        = $urandom;
        word[31:26] = memOps[3'($urandom)];
        return word;
    endfunction

    // Conditional branches, regimm branches, j/jal and jr/jalr
    function automatic logic [31:0] makeFlowInstr();
        logic [31:0] word;
        word = $urandom;
        case (2'($urandom))
            2'd0: word[31:26] = {4'b0001, 2'($urandom)};
            2'd1: begin
                word[31:26] = opTypeBI;
                word[20:16] = regimmCodes[2'($urandom)];
            end
            2'd2: word[31:26] = {5'b00001, 1'($urandom)};
            default: begin
                word[31:26] = opTypeR;
                word[5:0]   = {5'b00100, 1'($urandom)};
            end
        endcase
        return word;
    endfunction

    function automatic logic [31:0] makeAnyKnown();
        logic [1:0] sel;
        sel = 2'($urandom);
        if (sel == 2'd2) begin
            return makeMemInstr();
        end
        return (sel == 2'd3) ? makeFlowInstr() : makeAluInstr();
    endfunction

    task automatic finishTest(input string name, input int vectors);
        int newErrors;
        // Last vector is checked at this falling edge
        @(negedge clock);
        #1;
        newErrors = errorCount - errorsAtStart;
        errorsAtStart = errorCount;
        if (newErrors == 0) begin
            passedTests++;
            $display("Test %s: %0d vectors, no mismatches", name, vectors);
        end else begin
            failedTests++;
            $display("Test %s: %0d vectors, %0d mismatches", name, vectors, newErrors);
        end
    endtask

    task automatic driveVectors(input int kind, input int vectors, input string name);
        for (int i = 0; i < vectors; i++) begin
            @(negedge clock);
            {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} = 5'($urandom);
            idStall = (kind == kindStall) ? (($urandom % 3) == 0) : 1'b0;
            case (kind)
                kindAluImm: instr = makeAluInstr();
                kindMemory: instr = makeMemInstr();
                kindFlow:   instr = makeFlowInstr();
                kindStall:  instr = makeAnyKnown();
                default:    instr = $urandom;
            endcase
        end
        finishTest(name, vectors);
    endtask

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not complete within %0d ns", timeoutNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(26085));
        rstN    = 1'b0;
        instr   = '0;
        idStall = 1'b0;
        cmpEq   = 1'b0;
        cmpGz   = 1'b0;
        cmpGez  = 1'b0;
        cmpLz   = 1'b0;
        cmpLez  = 1'b0;
        repeat (resetCycles) @(negedge clock);
        rstN = 1'b1;
        finishTest("reset", resetCycles);
        driveVectors(kindAluImm, 600, "aluImmediate");
        driveVectors(kindMemory, 400, "loadStore");
        driveVectors(kindFlow, 600, "branchJump");
        driveVectors(kindStall, 300, "stall");
        driveVectors(kindUnknown, 300, "randomWord");
        $display("Tests passed: %0d, failed: %0d, mismatches: %0d in %0d compares",
            passedTests, failedTests, errorCount, checkCount);
        if (failedTests == 0 && checkCount > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/aluDecoder.sv
`timescale 1ns/1ns

module aluDecoder import mipsCtrlPkg::*; (
    input  opcode_e opCode,
    input  funct_e  funct,
    output aluOp_e  decodeAluOp
);

    aluOp_e rTypeOp;

    // R-type op selected by the funct field
    always_comb begin
        case (funct)
            fnAdd:      rTypeOp = aluAdd;
            fnAddu:     rTypeOp = aluAddu;
            fnSub:      rTypeOp = aluSub;
            fnSubu:     rTypeOp = aluSubu;
            fnAnd:      rTypeOp = aluAnd;
            fnOr:       rTypeOp = aluOr;
            fnXor:      rTypeOp = aluXor;
            fnNor:      rTypeOp = aluNor;
            fnSlt:      rTypeOp = aluSlt;
            fnSltu:     rTypeOp = aluSltu;
            fnSll:      rTypeOp = aluSll;
            fnSrl:      rTypeOp = aluSrl;
            fnSra:      rTypeOp = aluSra;
            fnSllv:     rTypeOp = aluSllv;
            fnSrlv:     rTypeOp = aluSrlv;
            fnSrav:     rTypeOp = aluSrav;
            // Return address passes through the adder
            fnJr, fnJalr: rTypeOp = aluAddu;
            default:    rTypeOp = bubbleAluOp;
        endcase
    end

    always_comb begin
        case (opCode)
            opTypeR:  decodeAluOp = rTypeOp;
            opAddi:   decodeAluOp = aluAdd;
            opAddiu:  decodeAluOp = aluAddu;
            opSlti:   decodeAluOp = aluSlt;
            opSltiu:  decodeAluOp = aluSltu;
            opAndi:   decodeAluOp = aluAnd;
            opOri:    decodeAluOp = aluOr;
            opXori:   decodeAluOp = aluXor;
            opLui:    decodeAluOp = aluSllc;
            // Address generation for memory ops
            opLb, opLh, opLw, opLbu, opLhu,
            opSb, opSh, opSw: decodeAluOp = aluAddu;
            // ALU result unused except for the link value
            opJ, opJal, opTypeBI,
            opBeq, opBne, opBlez, opBgtz: decodeAluOp = aluAddu;
            default:  decodeAluOp = bubbleAluOp;
        endcase
    end

endmodule

//--- hdl/idControlStage.sv
`timescale 1ns/1ns

module idControlStage import mipsCtrlPkg::*; (
    input  logic        clock,
    input  logic        rstN,
    input  logic        idStall,
    input  logic        cmpEq,
    input  logic        cmpGz,
    input  logic        cmpGez,
    input  logic        cmpLz,
    input  logic        cmpLez,
    input  pcSrc_e      decodePcSrc,
    input  branchCond_e brCond,
    input  aluOp_e      decodeAluOp,
    input  logic        decSignExtend,
    input  logic        decLink,
    input  logic        decRegDst,
    input  logic        decAluSrcImm,
    input  logic        decMemRead,
    input  logic        decMemWrite,
    input  logic        decMemByte,
    input  logic        decMemHalf,
    input  logic        decMemSignExtend,
    input  logic        decRegWrite,
    input  logic        decMemToReg,
    output pcSrc_e      pcSrc,
    output logic        nextIsDelay,
    output logic        signExtend,
    output logic        link,
    output logic        regDst,
    output logic        aluSrcImm,
    output aluOp_e      aluOp,
    output logic        memRead,
    output logic        memWrite,
    output logic        memByte,
    output logic        memHalf,
    output logic        memSignExtend,
    output logic        regWrite,
    output logic        memToReg
);

    logic   taken;
    logic   live;
    pcSrc_e resolvedPcSrc;

    always_comb begin
        case (brCond)
            brEq:    taken = cmpEq;
            brNe:    taken = !cmpEq;
            brGtz:   taken = cmpGz;
            brLez:   taken = cmpLez;
            brGez:   taken = cmpGez;
            brLtz:   taken = cmpLz;
            default: taken = 1'b0;
        endcase
    end

    // Untaken branches fall back to the sequential PC
    assign resolvedPcSrc = (decodePcSrc == pcBranch) ? (taken ? pcBranch : pcSeq) : decodePcSrc;
    assign live          = !idStall;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcSrc         <= pcSeq;
            nextIsDelay   <= 1'b0;
            signExtend    <= 1'b0;
            link          <= 1'b0;
            regDst        <= 1'b0;
            aluSrcImm     <= 1'b0;
            aluOp         <= bubbleAluOp;
            memRead       <= 1'b0;
            memWrite      <= 1'b0;
            memByte       <= 1'b0;
            memHalf       <= 1'b0;
            memSignExtend <= 1'b0;
            regWrite      <= 1'b0;
            memToReg      <= 1'b0;
        end else begin
            // Stall inserts a bubble into execute
            pcSrc         <= live ? resolvedPcSrc : pcSeq;
            nextIsDelay   <= live && (decodePcSrc != pcSeq);
            signExtend    <= live && decSignExtend;
            link          <= live && decLink;
            regDst        <= live && decRegDst;
            aluSrcImm     <= live && decAluSrcImm;
            aluOp         <= live ? decodeAluOp : bubbleAluOp;
            memRead       <= live && decMemRead;
            memWrite      <= live && decMemWrite;
            memByte       <= live && decMemByte;
            memHalf       <= live && decMemHalf;
            memSignExtend <= live && decMemSignExtend;
            regWrite      <= live && decRegWrite;
            memToReg      <= live && decMemToReg;
        end
    end

    // A slot is a load or a store, never both
    memAccessExcl: assert property (@(posedge clock) disable iff (!rstN)
        !(memRead && memWrite))
        else $error("memRead and memWrite both high");

    memSizeExcl: assert property (@(posedge clock) disable iff (!rstN)
        !(memByte && memHalf))
        else $error("memByte and memHalf both high");

    // Stalled slot reaches execute with no side effects
    stallBubble: assert property (@(posedge clock) disable iff (!rstN)
        idStall |=> (!regWrite && !memWrite))
        else $error("side effect after stalled decode");

endmodule

//--- hdl/mainDecoder.sv
`timescale 1ns/1ns

module mainDecoder import mipsCtrlPkg::*; (
    input  opcode_e     opCode,
    input  funct_e      funct,
    input  regimmRt_e   rt,
    output pcSrc_e      decodePcSrc,
    output branchCond_e brCond,
    output logic        signExtend,
    output logic        link,
    output logic        regDst,
    output logic        aluSrcImm,
    output logic        memRead,
    output logic        memWrite,
    output logic        memByte,
    output logic        memHalf,
    output logic        memSignExtend,
    output logic        regWrite,
    output logic        memToReg
);

    logic               known;
    logic [opWidth-1:0] opBits;

    assign opBits = opCode;

    always_comb begin
        known         = 1'b1;
        decodePcSrc   = pcSeq;
        brCond        = brNone;
        link          = 1'b0;
        regDst        = 1'b0;
        aluSrcImm     = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memByte       = 1'b0;
        memHalf       = 1'b0;
        memSignExtend = 1'b0;
        regWrite      = 1'b0;
        memToReg      = 1'b0;

        case (opCode)
            opTypeR: begin
                case (funct)
                    fnJr: decodePcSrc = pcJumpReg;
                    fnJalr: begin
                        decodePcSrc = pcJumpReg;
                        link        = 1'b1;
                        regDst      = 1'b1;
                        regWrite    = 1'b1;
                    end
                    fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                    fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
                        regDst   = 1'b1;
                        regWrite = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            // Regimm branches, with or without link
            opTypeBI: begin
                case (rt)
                    rtBltz, rtBltzal: brCond = brLtz;
                    rtBgez, rtBgezal: brCond = brGez;
                    default: known = 1'b0;
                endcase
                if (known) begin
                    decodePcSrc = pcBranch;
                    link        = (rt == rtBltzal) || (rt == rtBgezal);
                    regWrite    = link;
                end
            end
            opBeq, opBne, opBlez, opBgtz: begin
                decodePcSrc = pcBranch;
                case (opCode)
                    opBeq:   brCond = brEq;
                    opBne:   brCond = brNe;
                    opBlez:  brCond = brLez;
                    default: brCond = brGtz;
                endcase
            end
            opJ: decodePcSrc = pcJumpImm;
            opJal: begin
                decodePcSrc = pcJumpImm;
                link        = 1'b1;
                regWrite    = 1'b1;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opLb, opLh, opLw, opLbu, opLhu: begin
                aluSrcImm     = 1'b1;
                memRead       = 1'b1;
                regWrite      = 1'b1;
                memToReg      = 1'b1;
                memByte       = opCode inside {opLb, opLbu};
                memHalf       = opCode inside {opLh, opLhu};
                memSignExtend = opCode inside {opLb, opLh};
            end
            opSb, opSh, opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                memByte   = (opCode == opSb);
                memHalf   = (opCode == opSh);
            end
            default: known = 1'b0;
        endcase

        // Zero extension for the logical immediates and lui (opcodes 0011xx)
        signExtend = known && (opBits[5:2] != 4'b0011);
    end

endmodule

//--- hdl/mipsControl.sv
`timescale 1ns/1ns

module mipsControl import mipsCtrlPkg::*; (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic [instrWidth-1:0] instr,
    input  logic                  idStall,
    input  logic                  cmpEq,
    input  logic                  cmpGz,
    input  logic                  cmpGez,
    input  logic                  cmpLz,
    input  logic                  cmpLez,
    output pcSrc_e                pcSrc,
    output logic                  nextIsDelay,
    output logic                  signExtend,
    output logic                  link,
    output logic                  regDst,
    output logic                  aluSrcImm,
    output aluOp_e                aluOp,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  memByte,
    output logic                  memHalf,
    output logic                  memSignExtend,
    output logic                  regWrite,
    output logic                  memToReg
);

    opcode_e     opCode;
    funct_e      funct;
    regimmRt_e   rt;
    pcSrc_e      decodePcSrc;
    branchCond_e brCond;
    aluOp_e      decodeAluOp;
    logic        decSignExtend;
    logic        decLink;
    logic        decRegDst;
    logic        decAluSrcImm;
    logic        decMemRead;
    logic        decMemWrite;
    logic        decMemByte;
    logic        decMemHalf;
    logic        decMemSignExtend;
    logic        decRegWrite;
    logic        decMemToReg;

    // Instruction fields with rt at bits 20:16
    assign opCode = opcode_e'(instr[instrWidth-1 -: opWidth]);
    assign funct  = funct_e'(instr[functWidth-1:0]);
    assign rt     = regimmRt_e'(instr[16 +: regWidth]);

    mainDecoder u_mainDecoder (
        .opCode        (opCode),
        .funct         (funct),
        .rt            (rt),
        .decodePcSrc   (decodePcSrc),
        .brCond        (brCond),
        .signExtend    (decSignExtend),
        .link          (decLink),
        .regDst        (decRegDst),
        .aluSrcImm     (decAluSrcImm),
        .memRead       (decMemRead),
        .memWrite      (decMemWrite),
        .memByte       (decMemByte),
        .memHalf       (decMemHalf),
        .memSignExtend (decMemSignExtend),
        .regWrite      (decRegWrite),
        .memToReg      (decMemToReg)
    );

    aluDecoder u_aluDecoder (
        .opCode      (opCode),
        .funct       (funct),
        .decodeAluOp (decodeAluOp)
    );

    idControlStage u_idControlStage (
        .clock            (clock),
        .rstN             (rstN),
        .idStall          (idStall),
        .cmpEq            (cmpEq),
        .cmpGz            (cmpGz),
        .cmpGez           (cmpGez),
        .cmpLz            (cmpLz),
        .cmpLez           (cmpLez),
        .decodePcSrc      (decodePcSrc),
        .brCond           (brCond),
        .decodeAluOp      (decodeAluOp),
        .decSignExtend    (decSignExtend),
        .decLink          (decLink),
        .decRegDst        (decRegDst),
        .decAluSrcImm     (decAluSrcImm),
        .decMemRead       (decMemRead),
        .decMemWrite      (decMemWrite),
        .decMemByte       (decMemByte),
        .decMemHalf       (decMemHalf),
        .decMemSignExtend (decMemSignExtend),
        .decRegWrite      (decRegWrite),
        .decMemToReg      (decMemToReg),
        .pcSrc            (pcSrc),
        .nextIsDelay      (nextIsDelay),
        .signExtend       (signExtend),
        .link             (link),
        .regDst           (regDst),
        .aluSrcImm        (aluSrcImm),
        .aluOp            (aluOp),
        .memRead          (memRead),
        .memWrite         (memWrite),
        .memByte          (memByte),
        .memHalf          (memHalf),
        .memSignExtend    (memSignExtend),
        .regWrite         (regWrite),
        .memToReg         (memToReg)
    );

endmodule

//--- hdl/mipsCtrlPkg.sv
package mipsCtrlPkg;

    // Field widths of the instruction word
    localparam int instrWidth = 32;
    localparam int opWidth    = 6;
    localparam int functWidth = 6;
    localparam int regWidth   = 5;

    // Major opcodes handled by the decoder
    typedef enum logic [opWidth-1:0] {
        opTypeR  = 6'b000000,
        opTypeBI = 6'b000001,
        opJ      = 6'b000010,
        opJal    = 6'b000011,
        opBeq    = 6'b000100,
        opBne    = 6'b000101,
        opBlez   = 6'b000110,
        opBgtz   = 6'b000111,
        opAddi   = 6'b001000,
        opAddiu  = 6'b001001,
        opSlti   = 6'b001010,
        opSltiu  = 6'b001011,
        opAndi   = 6'b001100,
        opOri    = 6'b001101,
        opXori   = 6'b001110,
        opLui    = 6'b001111,
        opLb     = 6'b100000,
        opLh     = 6'b100001,
        opLw     = 6'b100011,
        opLbu    = 6'b100100,
        opLhu    = 6'b100101,
        opSb     = 6'b101000,
        opSh     = 6'b101001,
        opSw     = 6'b101011
    } opcode_e;

    // R-type function codes
    typedef enum logic [functWidth-1:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnNor  = 6'b100111,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } funct_e;

    // Branch selector carried in rt under the regimm opcode
    typedef enum logic [regWidth-1:0] {
        rtBltz   = 5'b00000,
        rtBgez   = 5'b00001,
        rtBltzal = 5'b10000,
        rtBgezal = 5'b10001
    } regimmRt_e;

    // Operations understood by the execute-stage ALU
    typedef enum logic [4:0] {
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluSllv,
        aluSrlv,
        aluSrav,
        aluSllc
    } aluOp_e;

    // Compare flag tested by a conditional branch
    typedef enum logic [2:0] {
        brNone,
        brEq,
        brNe,
        brGtz,
        brLez,
        brGez,
        brLtz
    } branchCond_e;

    // Next-PC choice
    typedef enum logic [1:0] {
        pcSeq     = 2'b00,
        pcJumpImm = 2'b01,
        pcBranch  = 2'b10,
        pcJumpReg = 2'b11
    } pcSrc_e;

    // Addu never traps, so it is safe for empty slots
    localparam aluOp_e bubbleAluOp = aluAddu;

endpackage

//--- mipsControl.f
hdl/mipsCtrlPkg.sv
hdl/mainDecoder.sv
hdl/aluDecoder.sv
hdl/idControlStage.sv
hdl/mipsControl.sv
dv/controlChecker.sv
dv/mipsControlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module mipsControlTb \
    -f mipsControl.f -o mipsControlSim \
    && ./obj_dir/mipsControlSim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

[ -f sim.log ] && cat sim.log
[ -f sim.log ] && ! grep -q "Simulation finished: FAIL" sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && exit 0 \
    || exit 1
